// ==== build.f ====
rtl/wb_pkg.sv
rtl/wb_arbiter.sv
rtl/wb_sel_mux.sv
rtl/wb_addr_decoder.sv
rtl/wb_resp_route.sv
rtl/wb_interconnect.sv
tests/tb_clock_gen.sv
tests/tb_wb_slaves.sv
tests/tb_wb_interconnect.sv

// ==== rtl/wb_addr_decoder.sv ====
// address decoder for the shared bus
// region decode from the top address bits
// per-slave request fan-out with gated cyc and stb
// registered slave index for the read data return
// error responder for unmapped regions
`timescale 1ns/1ps

module wb_addr_decoder (
	input  logic                                     sys_clk,
	input  logic                                     rst_n_i,
	// request of the granted master
	input  wb_pkg::wb_req_t                          bus_req_i,
	output wb_pkg::wb_req_t [wb_pkg::NUM_SLAVES-1:0] s_req_o,
	// slave index one cycle late, steers the response mux
	output logic [wb_pkg::SLAVE_IDX_W-1:0]           slv_idx_r_o,
	output wb_pkg::wb_rsp_t                          err_rsp_o
);

	// region field of the address
	logic [wb_pkg::REGION_W-1:0] region;
	// address lands in a mapped region
	logic hit;
	logic [wb_pkg::SLAVE_IDX_W-1:0] slv_idx;
	// one-hot slave select
	logic [wb_pkg::NUM_SLAVES-1:0] slv_sel;
	// cyc as seen by each slave
	logic [wb_pkg::NUM_SLAVES-1:0] s_cyc;
	logic [wb_pkg::SLAVE_IDX_W-1:0] slv_idx_r;
	// hole responder pulse
	logic err_r;

	assign region = bus_req_i.adr[wb_pkg::ADR_W-1:wb_pkg::REGION_LSB];
	assign hit = int'(region) < wb_pkg::NUM_REGIONS_MAPPED;
	// low bits of the region number the slave
	assign slv_idx = region[wb_pkg::SLAVE_IDX_W-1:0];

	// fan-out, shared fields go everywhere
	always_comb begin
		for (int k = 0; k < wb_pkg::NUM_SLAVES; k++) begin
			slv_sel[k] = hit && (int'(slv_idx) == k);
			s_req_o[k] = bus_req_i;
			// only the addressed slave sees the cycle
			s_req_o[k].cyc = bus_req_i.cyc & slv_sel[k];
			s_req_o[k].stb = bus_req_i.stb & slv_sel[k];
			s_cyc[k] = s_req_o[k].cyc;
		end
	end

	// select register and hole responder
	always_ff @(posedge sys_clk) begin
		if (!rst_n_i) begin
			slv_idx_r <= '0;
			err_r <= 1'b0;
		end else begin
			// read data select lags the address by one cycle
			slv_idx_r <= slv_idx;
			// err one cycle after stb on a hole, single pulse
			err_r <= bus_req_i.cyc & bus_req_i.stb & ~hit & ~err_r;
		end
	end

	assign slv_idx_r_o = slv_idx_r;

	// hole response carries no data and never acks
	always_comb begin
		err_rsp_o.dat = '0;
		err_rsp_o.ack = 1'b0;
		err_rsp_o.err = err_r;
	end

	// fan-out reaches at most one slave per cycle
	a_one_slave: assert property (
		@(posedge sys_clk) disable iff (!rst_n_i)
		$onehot0(s_cyc)
	) else $error("decoder drives cyc to several slaves");

	// a hole never reaches a slave
	a_no_hole_cyc: assert property (
		@(posedge sys_clk) disable iff (!rst_n_i)
		!hit |-> (s_cyc == '0)
	) else $error("decoder drives slave cyc on an unmapped address");

endmodule

// ==== rtl/wb_arbiter.sv ====
// round-robin bus arbiter
// grant follows the cyc lines of the masters
// owner keeps the bus for as long as it holds cyc
// search for the next owner starts after the current one
`timescale 1ns/1ps

module wb_arbiter (
	input  logic                            sys_clk,
	input  logic                            rst_n_i,
	// one cyc bit per master
	input  logic [wb_pkg::NUM_MASTERS-1:0]  req_i,
	output logic [wb_pkg::MASTER_IDX_W-1:0] gnt_o
);

	// current owner
	logic [wb_pkg::MASTER_IDX_W-1:0] gnt_r;
	// owner for the next cycle
	logic [wb_pkg::MASTER_IDX_W-1:0] gnt_nxt;

	// next owner search
	always_comb begin
		int cand;
		logic found;
		gnt_nxt = gnt_r;
		found = 1'b0;
		cand = 0;
		// only re-arbitrate once the owner lets go of cyc
		if (!req_i[gnt_r]) begin
			// walk the masters after the owner, wrapping around
			for (int k = 1; k < wb_pkg::NUM_MASTERS; k++) begin
				cand = (int'(gnt_r) + k) % wb_pkg::NUM_MASTERS;
				// first requester in cyclic order wins
				if (!found && req_i[cand]) begin
					found = 1'b1;
					gnt_nxt = cand[wb_pkg::MASTER_IDX_W-1:0];
				end
			end
		end
		// nobody asking, grant parks on the last owner
	end

	// grant register
	always_ff @(posedge sys_clk) begin
		if (!rst_n_i) begin
			// master 0 owns the bus out of reset
			gnt_r <= '0;
		end else begin
			gnt_r <= gnt_nxt;
		end
	end

	assign gnt_o = gnt_r;

	// grant always names an existing master
	a_gnt_range: assert property (
		@(posedge sys_clk) disable iff (!rst_n_i)
		int'(gnt_o) < wb_pkg::NUM_MASTERS
	) else $error("arbiter grant %0d out of range", gnt_o);

	// no preemption while the owner still holds cyc
	a_gnt_hold: assert property (
		@(posedge sys_clk) disable iff (!rst_n_i)
		req_i[gnt_o] |=> $stable(gnt_o)
	) else $error("arbiter grant moved under an active owner");

endmodule

// ==== rtl/wb_interconnect.sv ====
// shared-bus wishbone classic interconnect, three masters, four slaves
// round-robin arbiter on cyc, request mux, address decoder
// registered slave select for the response mux
// response router back to the granted master
`timescale 1ns/1ps

module wb_interconnect (
	input  logic                                      sys_clk,
	input  logic                                      rst_n_i,
	// master side
	input  wb_pkg::wb_req_t [wb_pkg::NUM_MASTERS-1:0] m_req_i,
	output wb_pkg::wb_rsp_t [wb_pkg::NUM_MASTERS-1:0] m_rsp_o,
	// slave side
	output wb_pkg::wb_req_t [wb_pkg::NUM_SLAVES-1:0]  s_req_o,
	input  wb_pkg::wb_rsp_t [wb_pkg::NUM_SLAVES-1:0]  s_rsp_i
);

	// cyc lines feeding the arbiter
	logic [wb_pkg::NUM_MASTERS-1:0] m_cyc;
	// current bus owner
	logic [wb_pkg::MASTER_IDX_W-1:0] gnt_idx;
	// request of the owner on the shared bus
	wb_pkg::wb_req_t bus_req;
	// slave index, one cycle behind the address
	logic [wb_pkg::SLAVE_IDX_W-1:0] slv_idx_r;
	// hole responder output
	wb_pkg::wb_rsp_t err_rsp;
	// response of the selected slave
	wb_pkg::wb_rsp_t bus_slv_rsp;

	for (genvar m = 0; m < wb_pkg::NUM_MASTERS; m++) begin : g_cyc
		assign m_cyc[m] = m_req_i[m].cyc;
	end

	wb_arbiter i_wb_arbiter (
		.sys_clk (sys_clk),
		.rst_n_i (rst_n_i),
		.req_i   (m_cyc),
		.gnt_o   (gnt_idx)
	);

	// owner request onto the shared bus
	wb_sel_mux #(
		.payload_t (wb_pkg::wb_req_t),
		.N         (wb_pkg::NUM_MASTERS)
	) i_req_mux (
		.data_i (m_req_i),
		.idx_i  (gnt_idx),
		.data_o (bus_req)
	);

	wb_addr_decoder i_wb_addr_decoder (
		.sys_clk     (sys_clk),
		.rst_n_i     (rst_n_i),
		.bus_req_i   (bus_req),
		.s_req_o     (s_req_o),
		.slv_idx_r_o (slv_idx_r),
		.err_rsp_o   (err_rsp)
	);

	// slave response picked by the registered select
	wb_sel_mux #(
		.payload_t (wb_pkg::wb_rsp_t),
		.N         (wb_pkg::NUM_SLAVES)
	) i_rsp_mux (
		.data_i (s_rsp_i),
		.idx_i  (slv_idx_r),
		.data_o (bus_slv_rsp)
	);

	wb_resp_route i_wb_resp_route (
		.slv_rsp_i (bus_slv_rsp),
		.err_rsp_i (err_rsp),
		.gnt_i     (gnt_idx),
		.m_rsp_o   (m_rsp_o)
	);

endmodule

// ==== rtl/wb_pkg.sv ====
// shared definitions for the wishbone classic interconnect
// bus sizes for three masters and four slaves
// address map, region field and mapped region count
// packed request and response structs
package wb_pkg;

	// bus population
	localparam int NUM_MASTERS = 3;
	localparam int NUM_SLAVES = 4;

	// index widths for grant and slave select
	localparam int MASTER_IDX_W = 2;
	localparam int SLAVE_IDX_W = 2;

	// field widths of the bus
	localparam int ADR_W = 32;
	localparam int DAT_W = 32;
	localparam int SEL_W = 4;
	localparam int CTI_W = 3;

	// address map, top nibble picks the region
	localparam int REGION_LSB = 28;
	localparam int REGION_W = ADR_W - REGION_LSB;
	// regions 0..3 go to slaves 0..3, the rest are holes
	localparam int NUM_REGIONS_MAPPED = 4;

	// master to slave request, 74 bits
	typedef struct packed {
		logic [ADR_W-1:0] adr;
		logic [DAT_W-1:0] dat;
		logic [SEL_W-1:0] sel;
		// burst type, carried but not decoded
		logic [CTI_W-1:0] cti;
		logic we;
		logic cyc;
		logic stb;
	} wb_req_t;

	// slave to master response, 34 bits
	typedef struct packed {
		logic [DAT_W-1:0] dat;
		logic ack;
		// bus error, from a slave or the hole responder
		logic err;
	} wb_rsp_t;

endpackage

// ==== rtl/wb_resp_route.sv ====
// response router back to the masters
// merges the selected slave response with the hole error
// read data goes to every master, ack and err to the owner only
`timescale 1ns/1ps

module wb_resp_route (
	// response of the selected slave
	input  wb_pkg::wb_rsp_t                           slv_rsp_i,
	// response of the hole responder
	input  wb_pkg::wb_rsp_t                           err_rsp_i,
	input  logic [wb_pkg::MASTER_IDX_W-1:0]           gnt_i,
	output wb_pkg::wb_rsp_t [wb_pkg::NUM_MASTERS-1:0] m_rsp_o
);

	// merged bus response
	wb_pkg::wb_rsp_t bus_rsp;

	// hole response has zero data, so an or is enough
	always_comb begin
		bus_rsp.dat = slv_rsp_i.dat | err_rsp_i.dat;
		bus_rsp.ack = slv_rsp_i.ack | err_rsp_i.ack;
		bus_rsp.err = slv_rsp_i.err | err_rsp_i.err;
	end

	// steer handshake to the owner, broadcast the data
	always_comb begin
		for (int m = 0; m < wb_pkg::NUM_MASTERS; m++) begin
			m_rsp_o[m].dat = bus_rsp.dat;
			m_rsp_o[m].ack = bus_rsp.ack && (int'(gnt_i) == m);
			m_rsp_o[m].err = bus_rsp.err && (int'(gnt_i) == m);
		end
	end

	// slave ack and hole err must never meet on the bus
	always_comb begin
		a_ack_err_excl: assert (!(bus_rsp.ack && bus_rsp.err))
			else $error("ack and err high together on the bus");
	end

endmodule

// ==== rtl/wb_sel_mux.sv ====
// index-select multiplexer over a generic payload type
// used for the granted master request and the slave response
// index past the last input gives an all-zero payload
`timescale 1ns/1ps

module wb_sel_mux #(
	parameter type payload_t = logic,
	// number of inputs, two or more
	parameter int N = 2
) (
	input  payload_t [N-1:0]         data_i,
	input  logic [$clog2(N)-1:0]     idx_i,
	output payload_t                 data_o
);

	always_comb begin
		// zero payload unless the index hits an input
		data_o = '0;
		// e.g. index 3 on a three input mux
		if (int'(idx_i) < N) begin
			data_o = data_i[idx_i];
		end
	end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# compile the interconnect testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -j 0 \
	-f build.f \
	--top-module tb_wb_interconnect \
	--Mdir "$BUILD_DIR" \
	-o tb_sim
if [ $? -ne 0 ]; then
	echo "compile failed"
	exit 1
fi

"./$BUILD_DIR/tb_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

# the log decides pass or fail
if grep -q "Something failed" "$LOG"; then
	exit 1
fi
exit 0

// ==== tests/tb_clock_gen.sv ====
// clock and reset source for the interconnect testbench
// 4 ns clock, reset held low for the first 10 rising edges
`timescale 1ns/1ps

module tb_clock_gen (
	output logic sys_clk,
	output logic rst_n_o
);

	// free running clock, 2 ns per half period
	initial begin
		sys_clk = 1'b0;
		forever #2 sys_clk = ~sys_clk;
	end

	// reset released on the tenth edge
	initial begin
		rst_n_o = 1'b0;
		repeat (10) @(posedge sys_clk);
		rst_n_o <= 1'b1;
	end

endmodule

// ==== tests/tb_wb_interconnect.sv ====
// testbench top for the wishbone interconnect
// three random master drivers and four memory slave models
// reference memory and round-robin grant model, checked every cycle
// cycle counter ends a hung run
`timescale 1ns/1ps

module tb_wb_interconnect;

	localparam int TXN_PER_MASTER = 60;
	// 8 cycles per transaction plus margin
	localparam int TIMEOUT_CYCLES = wb_pkg::NUM_MASTERS * TXN_PER_MASTER * 8 + 200;

	logic sys_clk;
	logic rst_n;
	wb_pkg::wb_req_t [wb_pkg::NUM_MASTERS-1:0] m_req;
	wb_pkg::wb_rsp_t [wb_pkg::NUM_MASTERS-1:0] m_rsp;
	wb_pkg::wb_req_t [wb_pkg::NUM_SLAVES-1:0] s_req;
	wb_pkg::wb_rsp_t [wb_pkg::NUM_SLAVES-1:0] s_rsp;
	logic [wb_pkg::NUM_MASTERS-1:0] master_done;

	// reference memory by full address
	logic [31:0] model_mem [logic [31:0]];
	// addresses written so far, read targets
	logic [31:0] written_q [$];
	// expected bus owner and its successor
	logic [1:0] model_gnt = '0;
	logic [1:0] gnt_next = '0;
	int mismatch_cnt = 0;
	int other_cnt = 0;
	int hang_cnt = 0;
	int txn_cnt = 0;
	int contention_cnt = 0;
	int after_rst_cnt = 0;

	tb_clock_gen i_clock_gen (
		.sys_clk (sys_clk),
		.rst_n_o (rst_n)
	);

	wb_interconnect i_wb_interconnect (
		.sys_clk (sys_clk),
		.rst_n_i (rst_n),
		.m_req_i (m_req),
		.m_rsp_o (m_rsp),
		.s_req_o (s_req),
		.s_rsp_i (s_rsp)
	);

	tb_wb_slaves i_slaves (
		.sys_clk (sys_clk),
		.rst_n_i (rst_n),
		.s_req_i (s_req),
		.s_rsp_o (s_rsp)
	);

	// about 10 percent holes, reads mostly hit written words
	function automatic logic [31:0] pick_address(input logic we);
		logic [3:0] region;
		logic [5:0] word;
		int unsigned roll;
		roll = $urandom_range(99);
		region = 4'($urandom_range(3));
		word = 6'($urandom_range(63));
		if (roll < 10) begin
			region = 4'(4 + $urandom_range(11));
		end else if (!we && written_q.size() > 0 && roll < 85) begin
			return written_q[$urandom_range(written_q.size() - 1)];
		end
		return {region, 20'h0, word, 2'b00};
	endfunction

	// one driver per master
	for (genvar m = 0; m < wb_pkg::NUM_MASTERS; m++) begin : g_master
		wb_pkg::wb_req_t req;
		int done_cnt;
		assign m_req[m] = req;
		assign master_done[m] = (done_cnt == TXN_PER_MASTER);
		initial begin
			logic we;
			req = '0;
			done_cnt = 0;
			wait (rst_n);
			repeat (TXN_PER_MASTER) begin
				@(posedge sys_clk);
				we = 1'($urandom_range(1));
				req.adr <= pick_address(we);
				req.dat <= $urandom();
				req.sel <= 4'hf;
				req.cti <= 3'b000;
				req.we <= we;
				req.cyc <= 1'b1;
				req.stb <= 1'b1;
				// hold the request until ack or err
				do begin
					@(negedge sys_clk);
				end while (!(m_rsp[m].ack || m_rsp[m].err));
				@(posedge sys_clk);
				req.cyc <= 1'b0;
				req.stb <= 1'b0;
				done_cnt++;
				// idle gap of 1 to 3 cycles
				repeat ($urandom_range(2)) @(posedge sys_clk);
			end
		end
	end

	// bus checks mid-cycle, all signals settled
	always @(negedge sys_clk) begin
		wb_pkg::wb_req_t own;
		wb_pkg::wb_req_t exp_req;
		logic [3:0] region;
		logic mapped;
		logic found;
		logic [wb_pkg::NUM_SLAVES-1:0] exp_cyc;
		logic [wb_pkg::NUM_SLAVES-1:0] act_cyc;
		logic [wb_pkg::NUM_MASTERS-1:0] hs;
		logic [31:0] exp_dat;
		int cand;
		own = m_req[model_gnt];
		region = own.adr[31:28];
		mapped = int'(region) < wb_pkg::NUM_REGIONS_MAPPED;
		for (int k = 0; k < wb_pkg::NUM_SLAVES; k++) begin
			exp_cyc[k] = own.cyc && mapped && (int'(region) == k);
			act_cyc[k] = s_req[k].cyc;
		end
		for (int k = 0; k < wb_pkg::NUM_MASTERS; k++) begin
			hs[k] = m_rsp[k].ack || m_rsp[k].err;
		end
		// reset and the first cycle after it stay quiet
		if (after_rst_cnt == 0 && (hs != '0 || act_cyc != '0)) begin
			$display("error: ack, err or slave cyc seen during reset or right after it");
			other_cnt++;
		end
		if (rst_n) begin
			after_rst_cnt++;
		end
		if (act_cyc != exp_cyc) begin
			$display("mismatch slave_cyc: expected %b actual %b", exp_cyc, act_cyc);
			mismatch_cnt++;
		end
		// shared fields reach every slave, cyc and stb only the addressed one
		for (int k = 0; k < wb_pkg::NUM_SLAVES; k++) begin
			exp_req = own;
			exp_req.cyc = exp_cyc[k];
			exp_req.stb = own.stb && mapped && (int'(region) == k);
			if (s_req[k] != exp_req) begin
				$display("mismatch slave_req: slave %0d expected %h actual %h",
					k, exp_req, s_req[k]);
				mismatch_cnt++;
			end
		end
		if ($countones(hs) > 1) begin
			$display("error: more than one master sees ack or err in one cycle");
			other_cnt++;
		end
		for (int k = 0; k < wb_pkg::NUM_MASTERS; k++) begin
			if (hs[k] && k != int'(model_gnt)) begin
				$display("mismatch ack_owner: expected %0d actual %0d", model_gnt, k);
				mismatch_cnt++;
			end
		end
		if (hs[model_gnt]) begin
			txn_cnt++;
			// a handshake only ends an open cycle
			if (!own.cyc || !own.stb) begin
				$display("error: ack or err reached master %0d with no open cycle",
					model_gnt);
				other_cnt++;
			end
			if (!mapped) begin
				// hole must end with err only
				if (m_rsp[model_gnt].ack || !m_rsp[model_gnt].err) begin
					$display("mismatch unmapped_resp: expected ack 0 err 1 actual ack %b err %b",
						m_rsp[model_gnt].ack, m_rsp[model_gnt].err);
					mismatch_cnt++;
				end
			end else if (m_rsp[model_gnt].err || !m_rsp[model_gnt].ack) begin
				$display("mismatch mapped_resp: expected ack 1 err 0 actual ack %b err %b",
					m_rsp[model_gnt].ack, m_rsp[model_gnt].err);
				mismatch_cnt++;
			end else if (own.we) begin
				model_mem[own.adr] = own.dat;
				written_q.push_back(own.adr);
			end else begin
				exp_dat = model_mem.exists(own.adr) ? model_mem[own.adr] : '0;
				// read data is broadcast to every master
				for (int k = 0; k < wb_pkg::NUM_MASTERS; k++) begin
					if (m_rsp[k].dat != exp_dat) begin
						$display("mismatch read_data: master %0d adr %h expected %h actual %h",
							k, own.adr, exp_dat, m_rsp[k].dat);
						mismatch_cnt++;
					end
				end
			end
		end
		if (m_req[0].cyc && m_req[1].cyc && m_req[2].cyc) begin
			contention_cnt++;
		end
		// next owner, searched after the current one once it lets go
		gnt_next = model_gnt;
		found = 1'b0;
		if (!m_req[model_gnt].cyc) begin
			for (int k = 1; k < wb_pkg::NUM_MASTERS; k++) begin
				cand = (int'(model_gnt) + k) % wb_pkg::NUM_MASTERS;
				if (!found && m_req[cand].cyc) begin
					found = 1'b1;
					gnt_next = 2'(cand);
				end
			end
		end
	end

	always @(posedge sys_clk) begin
		if (!rst_n) begin
			model_gnt <= '0;
		end else begin
			model_gnt <= gnt_next;
		end
	end

	initial begin
		int cycles;
		void'($urandom(32'h7f8b_f20f));
		cycles = 0;
		while (master_done != '1 && cycles < TIMEOUT_CYCLES) begin
			@(posedge sys_clk);
			cycles++;
		end
		if (master_done != '1) begin
			$display("error: masters still busy after %0d cycles, the bus hung", cycles);
			hang_cnt++;
		end
		@(negedge sys_clk);
		if (txn_cnt != wb_pkg::NUM_MASTERS * TXN_PER_MASTER) begin
			$display("error: %0d transactions completed on the bus instead of %0d",
				txn_cnt, wb_pkg::NUM_MASTERS * TXN_PER_MASTER);
			other_cnt++;
		end
		// round-robin order needs all three masters waiting at once
		if (contention_cnt == 0) begin
			$display("error: the three masters never waited at once, round-robin untested");
			other_cnt++;
		end
		$display("errors: %0d mismatch, %0d other, %0d hang; %0d txns, %0d contention cycles",
			mismatch_cnt, other_cnt, hang_cnt, txn_cnt, contention_cnt);
		if (mismatch_cnt == 0 && other_cnt == 0 && hang_cnt == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

// ==== tests/tb_wb_slaves.sv ====
// memory slave models for the interconnect testbench
// four word memories of 64 words, zero until written
// ack 1 to 3 cycles after stb starts, one cycle long
// write data lands in memory together with the ack
`timescale 1ns/1ps

module tb_wb_slaves (
	input  logic                                     sys_clk,
	input  logic                                     rst_n_i,
	input  wb_pkg::wb_req_t [wb_pkg::NUM_SLAVES-1:0] s_req_i,
	output wb_pkg::wb_rsp_t [wb_pkg::NUM_SLAVES-1:0] s_rsp_o
);

	localparam int MEM_WORDS = 64;

	// response registers, quiet from time zero
	wb_pkg::wb_rsp_t [wb_pkg::NUM_SLAVES-1:0] rsp_r = '0;
	logic [wb_pkg::DAT_W-1:0] mem [wb_pkg::NUM_SLAVES][MEM_WORDS];
	// word has been written since reset
	logic [MEM_WORDS-1:0] valid [wb_pkg::NUM_SLAVES];
	// cycles of stb seen so far
	int unsigned wait_cnt [wb_pkg::NUM_SLAVES];
	// ack delay of the current transfer
	int unsigned ack_dly [wb_pkg::NUM_SLAVES];

	assign s_rsp_o = rsp_r;

	always @(posedge sys_clk) begin
		logic [5:0] word;
		for (int s = 0; s < wb_pkg::NUM_SLAVES; s++) begin
			// word index inside the region
			word = s_req_i[s].adr[7:2];
			if (!rst_n_i) begin
				rsp_r[s] <= '0;
				wait_cnt[s] <= 0;
				ack_dly[s] <= 1;
				valid[s] <= '0;
			end else if (rsp_r[s].ack) begin
				// single cycle ack, master drops stb next
				rsp_r[s].ack <= 1'b0;
			end else if (s_req_i[s].cyc && s_req_i[s].stb) begin
				if (wait_cnt[s] + 1 >= ack_dly[s]) begin
					rsp_r[s].ack <= 1'b1;
					wait_cnt[s] <= 0;
					// delay for the next transfer, 1..3
					ack_dly[s] <= 1 + $urandom_range(2);
					if (s_req_i[s].we) begin
						mem[s][word] <= s_req_i[s].dat;
						valid[s][word] <= 1'b1;
					end else begin
						rsp_r[s].dat <= valid[s][word] ? mem[s][word] : '0;
					end
				end else begin
					wait_cnt[s] <= wait_cnt[s] + 1;
				end
			end
		end
	end

endmodule
